//--- sim.f
src/heapTypesPkg.sv
src/heapCommandPkg.sv
src/arrayDirectory.sv
src/elementStore.sv
src/heapControl.sv
src/arrayHeap.sv
dv/arrayHeapTb.sv

//--- Makefile
# Verilator build and run of the array heap testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 -Wno-fatal --top-module arrayHeapTb -f sim.f -o arrayHeapSim

run: compile
	./obj_dir/arrayHeapSim > $(LOG)
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- dv/arrayHeapTb.sv
//------------------------------------------------
// Directed testbench for the array heap at the
// default widths. A behavioral model predicts each
// response; one command is in flight except in Add.
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayHeapTb import heapTypesPkg::*, heapCommandPkg::*; ();

  localparam int clockPeriod     = 100;
  localparam int resetCycles     = 16;
  localparam int arrayCount      = 2 ** defaultAddressBits;
  localparam int arrayLength     = 2 ** defaultIndexBits;
  localparam int doneLimit       = 8;                   // Cycles to wait for done
  localparam int addCount        = 16;
  localparam int plannedCommands = 88;                  // 11+14+12+16+11+24 over six tests
  localparam int watchdogTime    = (resetCycles + 3 * plannedCommands + 40) * clockPeriod;

  logic       clock;
  logic       reset;
  logic       start;
  heapAction  action;
  arrayNumber arrayId;
  elementSlot index;
  dataWord    dataIn;
  logic       done;
  dataWord    dataOut;
  heapError   error;

  logic [31:0] lfsrState;
  int          errorCount;
  int          checkCount;
  int          testCount;

  // Reference model state
  bit      modelFlags [arrayCount];
  int      modelSizes [arrayCount];
  int      modelFreedStack [arrayCount];
  dataWord modelRows [arrayCount][arrayLength];
  int      modelHanded;                                 // Fresh numbers used
  int      modelFreedTop;
  dataWord modelLast;                                   // Last dataOut value
  bit      modelLastKnown;

  arrayHeap #(
    .addressBits(defaultAddressBits),
    .indexBits  (defaultIndexBits),
    .dataBits   (defaultDataBits)
  ) i_dut (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .action (action),
    .arrayId(arrayId),
    .index  (index),
    .dataIn (dataIn),
    .done   (done),
    .dataOut(dataOut),
    .error  (error)
  );

  initial clock = 1'b0;
  always #(clockPeriod / 2) clock = ~clock;

  //------------------------------------------------
  // Random bits and compare tasks
  //------------------------------------------------
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hD0000001) : (state >> 1);
  endfunction

  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int k = 0; k < count; k++) begin
      value     = {value[30:0], lfsrState[0]};          // One step per bit
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  task automatic checkData(input dataWord actual, input dataWord expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t ns: dataOut is %h, expected %h", $time, actual, expected);
    end
  endtask

  task automatic checkError(input heapError actual, input heapError expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t ns: error is %s (%0d), expected %s (%0d)", $time,
               actual.name(), actual, expected.name(), expected);
    end
  endtask

  task automatic checkDone(input logic seen, input heapAction act);
    checkCount++;
    if (seen !== 1'b1) begin
      errorCount++;
      $display("No done seen for the %s command at %0t ns", act.name(), $time);
    end
  endtask

  task automatic checkIdle(input logic seen);
    checkCount++;
    if (seen !== 1'b0) begin
      errorCount++;
      $display("FAILED at %0t ns: done is %b, expected 0", $time, seen);
    end
  endtask

  //------------------------------------------------
  // Reference model, one call per issued command
  //------------------------------------------------
  task automatic predict(input heapAction act, input arrayNumber id, input elementSlot idx,
                         input dataWord data, output dataWord expData, output heapError expErr);
    int      slot;
    dataWord result;
    bit      hasResult;
    expErr    = errNone;
    hasResult = 1'b0;
    result    = '0;
    if (act == actAlloc) begin
      if (modelFreedTop == 0 && modelHanded == arrayCount) expErr = errOutOfMemory;
    end else if (act != actReset) begin
      if (int'(id) >= modelHanded) expErr = errNotAllocated;
      else if (!modelFlags[id]) expErr = errFreed;
      else if ((act == actRead || act == actAdd) && int'(idx) >= modelSizes[id])
        expErr = errOutOfBounds;
      else if (act == actPush && modelSizes[id] == arrayLength) expErr = errFull;
      else if (act == actResize && int'(data) > arrayLength) expErr = errFull;
      else if ((act == actPop || act == actDown) && modelSizes[id] == 0) expErr = errEmpty;
    end
    if (expErr == errNone) begin
      hasResult = 1'b1;
      case (act)
        actReset: begin
          modelHanded   = 0;
          modelFreedTop = 0;
          for (int k = 0; k < arrayCount; k++) modelFlags[k] = 1'b0;
          hasResult = 1'b0;
        end
        actAlloc: begin
          if (modelFreedTop > 0) begin                  // Reuse most recently freed
            modelFreedTop--;
            slot = modelFreedStack[modelFreedTop];
          end else begin
            slot = modelHanded;
            modelHanded++;
          end
          modelFlags[slot] = 1'b1;
          modelSizes[slot] = 0;
          result           = dataWord'(slot);
        end
        actFree: begin
          modelFlags[id]                 = 1'b0;
          modelFreedStack[modelFreedTop] = int'(id);
          modelFreedTop++;
          hasResult = 1'b0;
        end
        actWrite: begin
          modelRows[id][idx] = data;
          if (int'(idx) + 1 > modelSizes[id]) modelSizes[id] = int'(idx) + 1;
          result = data;
        end
        actRead: result = modelRows[id][idx];
        actSize: result = dataWord'(modelSizes[id]);
        actResize: begin
          modelSizes[id] = int'(data);
          hasResult      = 1'b0;
        end
        actPush: begin
          modelRows[id][modelSizes[id]] = data;
          modelSizes[id]++;
          hasResult = 1'b0;
        end
        actPop: begin
          modelSizes[id]--;
          result = modelRows[id][modelSizes[id]];
        end
        actUp: begin
          for (int k = arrayLength - 1; k > int'(idx); k--) begin
            modelRows[id][k] = modelRows[id][k-1];
          end
          modelRows[id][idx] = data;
          if (modelSizes[id] < arrayLength) modelSizes[id]++;
          hasResult = 1'b0;
        end
        actDown: begin
          result = modelRows[id][idx];
          for (int k = int'(idx); k < arrayLength - 1; k++) begin
            modelRows[id][k] = modelRows[id][k+1];
          end
          modelSizes[id]--;
        end
        actAdd: begin
          result             = modelRows[id][idx] + data;  // Wraps at 12 bits
          modelRows[id][idx] = result;
        end
        default: hasResult = 1'b0;
      endcase
    end
    if (hasResult) begin
      modelLast      = result;
      modelLastKnown = 1'b1;
    end
    expData = modelLast;
  endtask

  //------------------------------------------------
  // Command driving
  //------------------------------------------------
  task automatic driveCommand(input heapAction act, input arrayNumber id,
                              input elementSlot idx, input dataWord data);
    start   <= 1'b1;
    action  <= act;
    arrayId <= id;
    index   <= idx;
    dataIn  <= data;
  endtask

  task automatic checkResponse(input heapAction act, input dataWord expData,
                               input heapError expErr, input bit dataKnown);
    checkDone(done, act);
    if (done === 1'b1) begin
      checkError(error, expErr);
      if (dataKnown) checkData(dataOut, expData);
    end
  endtask

  task automatic runCommand(input heapAction act, input arrayNumber id,
                            input elementSlot idx, input dataWord data);
    dataWord  expData;
    heapError expErr;
    bit       dataKnown;
    int       waited;
    predict(act, id, idx, data, expData, expErr);
    dataKnown = modelLastKnown;
    @(posedge clock);
    driveCommand(act, id, idx, data);
    @(negedge clock);
    checkIdle(done);                                    // Last done lasted one cycle
    @(posedge clock);
    start <= 1'b0;
    @(negedge clock);
    waited = 0;
    while (done !== 1'b1 && waited < doneLimit) begin
      @(negedge clock);
      waited++;
    end
    checkResponse(act, expData, expErr, dataKnown);
  endtask

  task automatic reportTest(input string name, input int firstErrors, input int firstChecks);
    testCount++;
    $display("Test %-10s %0d checks, %0d errors", name, checkCount - firstChecks,
             errorCount - firstErrors);
  endtask

  //------------------------------------------------
  // Directed tests
  //------------------------------------------------
  task automatic allocateAll();
    int firstErrors;
    int firstChecks;
    firstErrors = errorCount;
    firstChecks = checkCount;
    @(negedge clock);
    checkIdle(done);                                    // State right after reset
    checkError(error, errNone);
    for (int k = 0; k < arrayCount; k++) begin
      runCommand(actAlloc, 2'd0, 2'd0, 12'd0);
      checkData(dataOut, dataWord'(k));                 // Fresh numbers in order
      runCommand(actSize, arrayNumber'(k), 2'd0, 12'd0);
    end
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);
    runCommand(actReset, 2'd0, 2'd0, 12'd0);
    runCommand(actRead, 2'd2, 2'd0, 12'd0);
    reportTest("allocation", firstErrors, firstChecks);
  endtask

  task automatic writeAndRead();
    int          firstErrors;
    int          firstChecks;
    logic [31:0] bits;
    firstErrors = errorCount;
    firstChecks = checkCount;
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);            // Array 0
    takeBits(defaultDataBits, bits);
    runCommand(actWrite, 2'd0, 2'd1, dataWord'(bits));
    takeBits(defaultDataBits, bits);
    runCommand(actWrite, 2'd0, 2'd0, dataWord'(bits));
    runCommand(actRead, 2'd0, 2'd0, 12'd0);
    runCommand(actRead, 2'd0, 2'd1, 12'd0);
    runCommand(actRead, 2'd0, 2'd2, 12'd0);             // At the size
    runCommand(actSize, 2'd0, 2'd0, 12'd0);
    takeBits(defaultDataBits, bits);
    runCommand(actWrite, 2'd0, 2'd3, dataWord'(bits));
    runCommand(actSize, 2'd0, 2'd0, 12'd0);
    runCommand(actResize, 2'd0, 2'd0, 12'd3);
    runCommand(actSize, 2'd0, 2'd0, 12'd0);
    runCommand(actRead, 2'd0, 2'd3, 12'd0);             // Beyond the new size
    runCommand(actResize, 2'd0, 2'd0, 12'd5);
    runCommand(actSize, 2'd0, 2'd0, 12'd0);
    reportTest("writeRead", firstErrors, firstChecks);
  endtask

  task automatic pushAndPop();
    int          firstErrors;
    int          firstChecks;
    logic [31:0] bits;
    firstErrors = errorCount;
    firstChecks = checkCount;
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);            // Array 1
    runCommand(actPop, 2'd1, 2'd0, 12'd0);
    for (int k = 0; k < arrayLength; k++) begin
      takeBits(defaultDataBits, bits);
      runCommand(actPush, 2'd1, 2'd0, dataWord'(bits));
    end
    runCommand(actPush, 2'd1, 2'd0, 12'd7);
    for (int k = 0; k < arrayLength; k++) begin
      runCommand(actPop, 2'd1, 2'd0, 12'd0);
    end
    runCommand(actPop, 2'd1, 2'd0, 12'd0);
    reportTest("pushPop", firstErrors, firstChecks);
  endtask

  task automatic shiftProgram();
    int firstErrors;
    int firstChecks;
    firstErrors = errorCount;
    firstChecks = checkCount;
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);            // Array 2
    for (int k = 0; k < 3; k++) begin
      runCommand(actWrite, 2'd2, elementSlot'(k), dataWord'(k));
    end
    runCommand(actResize, 2'd2, 2'd0, 12'd3);
    runCommand(actUp, 2'd2, 2'd0, 12'd99);
    for (int k = 0; k < arrayLength; k++) begin
      runCommand(actRead, 2'd2, elementSlot'(k), 12'd0);
    end
    runCommand(actSize, 2'd2, 2'd0, 12'd0);
    runCommand(actDown, 2'd2, 2'd1, 12'd0);
    checkData(dataOut, 12'd0);                          // Removed element
    for (int k = 0; k < 3; k++) begin
      runCommand(actRead, 2'd2, elementSlot'(k), 12'd0);
    end
    runCommand(actSize, 2'd2, 2'd0, 12'd0);
    reportTest("shift", firstErrors, firstChecks);
  endtask

  task automatic freeAndReuse();
    int firstErrors;
    int firstChecks;
    firstErrors = errorCount;
    firstChecks = checkCount;
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);            // Array 3, heap now full
    runCommand(actFree, 2'd1, 2'd0, 12'd0);
    runCommand(actFree, 2'd3, 2'd0, 12'd0);
    runCommand(actRead, 2'd1, 2'd0, 12'd0);
    runCommand(actSize, 2'd3, 2'd0, 12'd0);
    runCommand(actWrite, 2'd1, 2'd0, 12'd5);
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);            // Last freed comes back first
    runCommand(actSize, 2'd3, 2'd0, 12'd0);
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);
    runCommand(actSize, 2'd1, 2'd0, 12'd0);
    runCommand(actAlloc, 2'd0, 2'd0, 12'd0);
    reportTest("freeReuse", firstErrors, firstChecks);
  endtask

  task automatic addStream();
    int          firstErrors;
    int          firstChecks;
    logic [31:0] bits;
    elementSlot  idx;
    dataWord     expData;
    heapError    expErr;
    dataWord     prevData;
    heapError    prevErr;
    firstErrors = errorCount;
    firstChecks = checkCount;
    for (int k = 0; k < arrayLength; k++) begin
      takeBits(defaultDataBits, bits);
      runCommand(actWrite, 2'd0, elementSlot'(k), dataWord'(bits));
    end
    prevData = '0;
    prevErr  = errNone;
    for (int k = 0; k <= addCount; k++) begin
      @(posedge clock);
      if (k < addCount) begin
        takeBits(defaultIndexBits, bits);
        idx = elementSlot'(bits);
        takeBits(defaultDataBits, bits);
        predict(actAdd, 2'd0, idx, dataWord'(bits), expData, expErr);
        driveCommand(actAdd, 2'd0, idx, dataWord'(bits));
      end else begin
        start <= 1'b0;
      end
      if (k > 0) begin
        @(negedge clock);                               // Result of the previous Add
        checkResponse(actAdd, prevData, prevErr, 1'b1);
      end
      prevData = expData;
      prevErr  = expErr;
    end
    for (int k = 0; k < arrayLength; k++) begin
      runCommand(actRead, 2'd0, elementSlot'(k), 12'd0);
    end
    reportTest("addStream", firstErrors, firstChecks);
  endtask

  //------------------------------------------------
  // Sequence and watchdog
  //------------------------------------------------
  initial begin
    reset          = 1'b0;
    start          = 1'b0;
    action         = actReset;
    arrayId        = '0;
    index          = '0;
    dataIn         = '0;
    lfsrState      = 32'h89474eb7;
    errorCount     = 0;
    checkCount     = 0;
    testCount      = 0;
    modelHanded    = 0;
    modelFreedTop  = 0;
    modelLast      = '0;
    modelLastKnown = 1'b0;                              // dataOut has no reset value
    for (int k = 0; k < arrayCount; k++) begin
      modelFlags[k] = 1'b0;
      modelSizes[k] = 0;
    end
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b1;
    allocateAll();
    writeAndRead();
    pushAndPop();
    shiftProgram();
    freeAndReuse();
    addStream();
    $display("Tests run %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(watchdogTime);
    $display("Watchdog expired at %0t ns before the tests finished", $time);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/arrayHeap.sv
//------------------------------------------------
// Array heap top level. One command per strobe,
// answered by done on the next rising edge.
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayHeap import heapTypesPkg::*, heapCommandPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  heapAction              action,
  input  logic [addressBits-1:0] arrayId,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   done,
  output logic [dataBits-1:0]    dataOut,
  output heapError               error
);

  logic                   dirClear;
  logic                   dirAlloc;
  logic                   dirFree;
  logic                   sizeWrite;
  logic [indexBits:0]     newSize;
  logic                   allocated;
  logic                   everAllocated;
  logic [indexBits:0]     arraySize;
  logic [addressBits-1:0] allocId;
  logic                   allocAvailable;
  storeOperation          storeOp;
  logic [indexBits-1:0]   elementIndex;
  logic [dataBits-1:0]    element;

  heapControl #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) control (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .action        (action),
    .index         (index),
    .dataIn        (dataIn),
    .allocated     (allocated),
    .everAllocated (everAllocated),
    .arraySize     (arraySize),
    .allocId       (allocId),
    .allocAvailable(allocAvailable),
    .element       (element),
    .dirClear      (dirClear),
    .dirAlloc      (dirAlloc),
    .dirFree       (dirFree),
    .sizeWrite     (sizeWrite),
    .newSize       (newSize),
    .storeOp       (storeOp),
    .elementIndex  (elementIndex),
    .done          (done),
    .dataOut       (dataOut),
    .error         (error)
  );

  arrayDirectory #(
    .addressBits(addressBits),
    .indexBits  (indexBits)
  ) directory (
    .clock         (clock),
    .reset         (reset),
    .arrayId       (arrayId),
    .dirClear      (dirClear),
    .dirAlloc      (dirAlloc),
    .dirFree       (dirFree),
    .sizeWrite     (sizeWrite),
    .newSize       (newSize),
    .allocated     (allocated),
    .everAllocated (everAllocated),
    .arraySize     (arraySize),
    .allocId       (allocId),
    .allocAvailable(allocAvailable)
  );

  elementStore #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) store (
    .clock       (clock),
    .arrayId     (arrayId),
    .elementIndex(elementIndex),
    .dataIn      (dataIn),
    .storeOp     (storeOp),
    .element     (element)
  );

endmodule

`default_nettype wire

//--- src/heapControl.sv
//------------------------------------------------
// Command decode and operand checks. A command is
// judged in the cycle of its strobe; a failing
// command drives no enable. dataBits must exceed
// indexBits so that sizes fit a data word.
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module heapControl import heapCommandPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  heapAction              action,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  input  logic                   allocated,
  input  logic                   everAllocated,
  input  logic [indexBits:0]     arraySize,
  input  logic [addressBits-1:0] allocId,
  input  logic                   allocAvailable,
  input  logic [dataBits-1:0]    element,
  output logic                   dirClear,
  output logic                   dirAlloc,
  output logic                   dirFree,
  output logic                   sizeWrite,
  output logic [indexBits:0]     newSize,
  output storeOperation          storeOp,
  output logic [indexBits-1:0]   elementIndex,
  output logic                   done,
  output logic [dataBits-1:0]    dataOut,
  output heapError               error
);

  localparam int arrayLength = 2 ** indexBits;
  localparam int sizeBits    = indexBits + 1;
  localparam logic [sizeBits-1:0] fullSize = sizeBits'(arrayLength);

  heapError            checkError;
  logic                goodCommand;                     // Strobed and error free
  logic [sizeBits-1:0] sizeLessOne;
  logic [sizeBits-1:0] indexPlusOne;
  logic [dataBits-1:0] result;
  logic                resultValid;                     // Command updates dataOut

  assign sizeLessOne  = arraySize - 1'b1;
  assign indexPlusOne = sizeBits'(index) + 1'b1;
  assign goodCommand  = start && (checkError == errNone);

  //------------------------------------------------
  // Operand checks
  //------------------------------------------------
  always_comb begin
    checkError = errNone;
    case (action)
      actAlloc: begin
        if (!allocAvailable) begin
          checkError = errOutOfMemory;
        end
      end
      actWrite, actRead, actSize, actUp, actDown, actPush, actPop, actResize,
      actFree, actAdd: begin
        if (!everAllocated) begin
          checkError = errNotAllocated;
        end else if (!allocated) begin
          checkError = errFreed;
        end else begin
          case (action)
            actRead, actAdd: begin
              if (sizeBits'(index) >= arraySize) begin
                checkError = errOutOfBounds;
              end
            end
            actPush: begin
              if (arraySize == fullSize) begin
                checkError = errFull;
              end
            end
            actResize: begin
              if (dataIn > dataBits'(arrayLength)) begin
                checkError = errFull;
              end
            end
            actPop, actDown: begin
              if (arraySize == '0) begin
                checkError = errEmpty;
              end
            end
            default: ;
          endcase
        end
      end
      default: ;                                        // Reset and unknown codes pass
    endcase
  end

  //------------------------------------------------
  // Datapath steering and next size
  //------------------------------------------------
  always_comb begin
    dirClear     = 1'b0;
    dirAlloc     = 1'b0;
    dirFree      = 1'b0;
    sizeWrite    = 1'b0;
    newSize      = arraySize;
    storeOp      = opNone;
    elementIndex = index;
    case (action)
      actReset: dirClear = 1'b1;
      actAlloc: dirAlloc = 1'b1;
      actFree:  dirFree  = 1'b1;
      actAdd:   storeOp  = opAdd;
      actWrite: begin
        storeOp   = opWrite;
        sizeWrite = 1'b1;
        if (indexPlusOne > arraySize) begin             // Only ever grows
          newSize = indexPlusOne;
        end
      end
      actUp: begin
        storeOp   = opUp;
        sizeWrite = 1'b1;
        if (arraySize != fullSize) begin                // Full row drops its top
          newSize = arraySize + 1'b1;
        end
      end
      actDown: begin
        storeOp   = opDown;
        sizeWrite = 1'b1;
        newSize   = sizeLessOne;
      end
      actPush: begin
        storeOp      = opWrite;
        elementIndex = arraySize[indexBits-1:0];        // First free slot
        sizeWrite    = 1'b1;
        newSize      = arraySize + 1'b1;
      end
      actPop: begin
        elementIndex = sizeLessOne[indexBits-1:0];      // Last used slot
        sizeWrite    = 1'b1;
        newSize      = sizeLessOne;
      end
      actResize: begin
        sizeWrite = 1'b1;
        newSize   = dataIn[indexBits:0];
      end
      default: ;
    endcase
    if (!goodCommand) begin
      dirClear  = 1'b0;
      dirAlloc  = 1'b0;
      dirFree   = 1'b0;
      sizeWrite = 1'b0;
      storeOp   = opNone;
    end
  end

  //------------------------------------------------
  // Result word and registered response
  //------------------------------------------------
  always_comb begin
    result      = element;                              // Read, Pop and Down
    resultValid = 1'b1;
    case (action)
      actRead, actPop, actDown: result = element;
      actWrite: result = dataIn;
      actSize:  result = dataBits'(arraySize);
      actAlloc: result = dataBits'(allocId);
      actAdd:   result = element + dataIn;              // Wraps at data width
      default:  resultValid = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      done  <= 1'b0;
      error <= errNone;
    end else begin
      done  <= start;
      error <= start ? checkError : errNone;
    end
  end

  always_ff @(posedge clock) begin
    if (goodCommand && resultValid) begin
      dataOut <= result;                                // Held between results
    end
  end

endmodule

`default_nettype wire

//--- src/elementStore.sv
//------------------------------------------------
// Element rows, one per array, with no reset.
// Up and Down move the whole row in one cycle.
// Needs indexBits of at least one.
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module elementStore import heapCommandPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic [addressBits-1:0] arrayId,
  input  logic [indexBits-1:0]   elementIndex,
  input  logic [dataBits-1:0]    dataIn,
  input  storeOperation          storeOp,
  output logic [dataBits-1:0]    element
);

  localparam int arrayCount  = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  logic [dataBits-1:0] rows [arrayCount][arrayLength];
  logic [dataBits-1:0] currentRow [arrayLength];        // Row of the addressed array
  logic [dataBits-1:0] upRow [arrayLength];
  logic [dataBits-1:0] downRow [arrayLength];

  assign currentRow = rows[arrayId];
  assign element    = currentRow[elementIndex];

  //------------------------------------------------
  // Shifted rows
  //------------------------------------------------
  always_comb begin
    upRow[0] = (elementIndex == '0) ? dataIn : currentRow[0];
    for (int k = 1; k < arrayLength; k++) begin
      if (k < int'(elementIndex)) begin
        upRow[k] = currentRow[k];                       // Below the gap
      end else if (k == int'(elementIndex)) begin
        upRow[k] = dataIn;                              // Inserted value
      end else begin
        upRow[k] = currentRow[k-1];                     // Top element falls off
      end
    end
  end

  always_comb begin
    for (int k = 0; k < arrayLength - 1; k++) begin
      if (k < int'(elementIndex)) begin
        downRow[k] = currentRow[k];
      end else begin
        downRow[k] = currentRow[k+1];                   // Close over the removed slot
      end
    end
    downRow[arrayLength-1] = currentRow[arrayLength-1]; // Top stays, beyond the size
  end

  //------------------------------------------------
  // Row update
  //------------------------------------------------
  always_ff @(posedge clock) begin
    case (storeOp)
      opWrite: rows[arrayId][elementIndex] <= dataIn;
      opAdd:   rows[arrayId][elementIndex] <= element + dataIn;
      opUp:    rows[arrayId] <= upRow;
      opDown:  rows[arrayId] <= downRow;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/arrayDirectory.sv
//------------------------------------------------
// Allocation flags, sizes and the freed stack.
// Expects at most one enable per cycle and no
// free of an array that is already free.
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayDirectory #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [addressBits-1:0] arrayId,
  input  logic                   dirClear,
  input  logic                   dirAlloc,
  input  logic                   dirFree,
  input  logic                   sizeWrite,
  input  logic [indexBits:0]     newSize,
  output logic                   allocated,
  output logic                   everAllocated,
  output logic [indexBits:0]     arraySize,
  output logic [addressBits-1:0] allocId,
  output logic                   allocAvailable
);

  localparam int arrayCount = 2 ** addressBits;
  localparam int countBits  = addressBits + 1;

  logic [arrayCount-1:0]  allocFlags;
  logic [countBits-1:0]   handedOut;                    // Fresh numbers used so far
  logic [countBits-1:0]   freedTop;                     // Entries on the freed stack
  logic [addressBits-1:0] freedStack [arrayCount];
  logic [indexBits:0]     sizes [arrayCount];
  logic                   reuseFreed;
  logic [addressBits-1:0] topSlot;
  logic [addressBits-1:0] pushSlot;

  assign reuseFreed     = freedTop != '0;
  assign topSlot        = addressBits'(freedTop - 1'b1);
  assign pushSlot       = addressBits'(freedTop);
  assign allocId        = reuseFreed ? freedStack[topSlot] : handedOut[addressBits-1:0];
  assign allocAvailable = reuseFreed || (handedOut != countBits'(arrayCount));
  assign everAllocated  = countBits'(arrayId) < handedOut;
  assign allocated      = allocFlags[arrayId];
  assign arraySize      = sizes[arrayId];

  //------------------------------------------------
  // Allocation state
  //------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocFlags <= '0;
      handedOut  <= '0;
      freedTop   <= '0;
    end else if (dirClear) begin
      allocFlags <= '0;
      handedOut  <= '0;
      freedTop   <= '0;
    end else begin
      if (dirAlloc) begin
        allocFlags[allocId] <= 1'b1;
        if (reuseFreed) begin                           // Most recently freed first
          freedTop <= freedTop - 1'b1;
        end else begin
          handedOut <= handedOut + 1'b1;
        end
      end
      if (dirFree) begin
        allocFlags[arrayId] <= 1'b0;
        freedTop            <= freedTop + 1'b1;
      end
    end
  end

  // Stack entries and sizes
  always_ff @(posedge clock) begin
    if (dirFree) begin
      freedStack[pushSlot] <= arrayId;
    end
    if (dirAlloc) begin
      sizes[allocId] <= '0;                             // New array starts empty
    end else if (sizeWrite) begin
      sizes[arrayId] <= newSize;
    end
  end

endmodule

`default_nettype wire

//--- src/heapCommandPkg.sv
//------------------------------------------------
// Command set of the array heap. Action codes keep
// the numbering of the older heap, so gaps remain
// where commands were removed.
//------------------------------------------------
`default_nettype none

package heapCommandPkg;

  typedef enum logic [4:0] {
    actReset  = 5'd1,                                   // Forget every array
    actWrite  = 5'd2,
    actRead   = 5'd3,
    actSize   = 5'd4,
    actUp     = 5'd10,                                  // Insert with shift up
    actDown   = 5'd11,                                  // Remove with shift down
    actPush   = 5'd14,
    actPop    = 5'd15,
    actResize = 5'd17,
    actAlloc  = 5'd18,
    actFree   = 5'd19,
    actAdd    = 5'd20                                   // Returns the new sum
  } heapAction;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                             // Never handed out
    errFreed        = 3'd2,                             // Handed out, then freed
    errOutOfBounds  = 3'd3,                             // Index at or past size
    errFull         = 3'd4,
    errEmpty        = 3'd5,
    errOutOfMemory  = 3'd6                              // No array left to alloc
  } heapError;

  // Element store operation, one per committed command
  typedef enum logic [2:0] {
    opNone  = 3'd0,
    opWrite = 3'd1,
    opAdd   = 3'd2,
    opUp    = 3'd3,
    opDown  = 3'd4
  } storeOperation;

endpackage

`default_nettype wire

//--- src/heapTypesPkg.sv
//------------------------------------------------
// Default widths of the array heap and word types
// built on them. Modules take their widths as
// parameters, so these types fit only a heap
// built with the defaults.
//------------------------------------------------
`default_nettype none

package heapTypesPkg;

  //------------------------------------------------
  // Default widths
  //------------------------------------------------
  parameter int defaultAddressBits = 2;                 // Four arrays
  parameter int defaultIndexBits   = 2;                 // Four elements per array
  parameter int defaultDataBits    = 12;                // Element width

  //------------------------------------------------
  // Words at the default widths
  //------------------------------------------------
  typedef logic [defaultAddressBits-1:0] arrayNumber;   // Which array
  typedef logic [defaultIndexBits-1:0]   elementSlot;   // Position in an array
  typedef logic [defaultIndexBits:0]     arrayFill;     // Size, zero to full length
  typedef logic [defaultDataBits-1:0]    dataWord;      // One element

endpackage

`default_nettype wire
